/* microcode.hex */
// Microprogram image, one 48-bit word per line from address 0x00
// Fields seq[46:43] next[42:35] csel[34:32] inv[31] ysrc[30:28] ydst[27:25] arb[24:23] ff[22:20] lit[19:0]
700012500100    // 00 Address 0x100, pointer 0
601800200000    // 01 Counter 3, clear TR0
088000800000    // 02 Read request, call bus wait
700026600000    // 03 Read data to modifier, pointer + 1
481000700000    // 04 Loop to 02, address + 1
700012500200    // 05 Address 0x200, pointer 0
601800000000    // 06 Counter 3
187230000000    // 07 Modifier zero goes to 0E
088035000000    // 08 Modifier to write data, write, call wait
700000600000    // 09 Pointer + 1
483800700000    // 0A Loop to 07, address + 1
7000120002FF    // 0B Address 0x2FF
088045000000    // 0C Status to write data, write, call wait
186800000000    // 0D Halt loop
08801510DEAD    // 0E Literal to write data, set TR0, write, call wait
184800000000    // 0F Rejoin at 09
188180000000    // 10 Bus wait, spin until ready
500000000000    // 11 Return

/* compile.f */
+incdir+.
micro_pkg.sv
microsequencer.sv
micro_control.sv
flag_triggers.sv
modifier_memory.sv
bus_arbiter.sv
cpu_core.sv
tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - micro_pkg.sv
      - microsequencer.sv
      - micro_control.sv
      - flag_triggers.sv
      - modifier_memory.sv
      - bus_arbiter.sv
      - cpu_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_core.sv

/* tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------------------------------------------
// Compare tasks, one per result kind
task automatic compare_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
        fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic compare_addr(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
        fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic compare_strobes(input string name, input arb_state_t got,
                               input arb_state_t exp);
    if (got !== exp)
        fail_run($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

// Bus phase as seen on the pins, DONE never shows outside
function automatic arb_state_t decode_strobes(input logic astb, input logic rd,
                                              input logic wr);
    arb_state_t phase;
    phase = ST_IDLE;
    if (astb)
        phase = ST_ADDR;
    else if (rd || wr)
        phase = ST_DATA;
    return phase;
endfunction

// ----------------------------------------------------------------------------
// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

/* tb_cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;
    import micro_pkg::*;

    localparam int N_TESTS     = 5;
    localparam int TEST_CYCLES = 2000;                         // Budget per test
    localparam int CYCLE_LIMIT = N_TESTS * TEST_CYCLES;
    localparam int HALT_IDLE   = 50;                           // Quiet cycles mean halted
    localparam logic [DATA_W-1:0] SRC_BASE    = 64'h100;
    localparam logic [DATA_W-1:0] DST_BASE    = 64'h200;
    localparam logic [DATA_W-1:0] STATUS_ADDR = 64'h2FF;
    localparam logic [DATA_W-1:0] ZERO_FILL   = 64'h0DEAD;     // Literal for zero words

    logic              clk = 1'b0;
    logic              reset;
    logic [DATA_W-1:0] mem_data;
    logic [DATA_W-1:0] ad;
    logic              astb;
    logic              rd;
    logic              wr;
    logic [DATA_W-1:0] src_words [4];                          // Memory at 0x100..0x103
    logic [DATA_W-1:0] bus_addr;                               // Latched on o_astb
    logic [DATA_W-1:0] rd_addr_q [$];
    logic [DATA_W-1:0] wr_addr_q [$];
    logic [DATA_W-1:0] wr_data_q [$];
    arb_state_t        prev_phase = ST_IDLE;
    logic              status_seen;
    int                idle_cycles;
    int                cycle_count = 0;
    logic [31:0]       rng;

    cpu_core u_dut (
        .clk(clk), .reset(reset), .i_data(mem_data),
        .o_ad(ad), .o_astb(astb), .o_rd(rd), .o_wr(wr)
    );

    always #10 clk = ~clk;                                     // 20 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

`include "tb_checks.svh"

    // ------------------------------------------------------------------------
    // Memory model and bus monitor
    function automatic logic [DATA_W-1:0] mem_word(input logic [DATA_W-1:0] addr);
        if (addr >= SRC_BASE && addr < SRC_BASE + 4)
            return src_words[addr[1:0]];
        return ~addr;                                          // Fill follows whole address
    endfunction

    always @(posedge clk)
        mem_data <= mem_word(bus_addr);                        // Valid through DATA phase

    always @(negedge clk) begin
        if ($isunknown({astb, rd, wr}))
            fail_run("Bus strobes are unknown");
        if (int'(astb) + int'(rd) + int'(wr) > 1)
            fail_run("Bus strobes overlap");
        if (reset) begin
            compare_strobes("strobes in reset", decode_strobes(astb, rd, wr), ST_IDLE);
            compare_data("o_ad in reset", ad, '0);
            prev_phase = ST_IDLE;
        end else begin
            if (prev_phase == ST_ADDR)
                compare_strobes("phase after o_astb", decode_strobes(astb, rd, wr), ST_DATA);
            else if (rd || wr)
                fail_run("o_rd or o_wr came without an o_astb the cycle before");
            if (status_seen && (astb || rd || wr))
                fail_run("Bus activity after the status write");
            if (astb)
                bus_addr = ad;
            if (rd)
                rd_addr_q.push_back(bus_addr);
            if (wr) begin
                wr_addr_q.push_back(bus_addr);
                wr_data_q.push_back(ad);                       // Write data on o_ad
                status_seen = (bus_addr == STATUS_ADDR);
            end
            idle_cycles = (astb || rd || wr) ? 0 : idle_cycles + 1;
            prev_phase  = decode_strobes(astb, rd, wr);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            fail_run("Timeout, the microprogram never reached its halt loop");
    end

    // ------------------------------------------------------------------------
    // Test helpers
    task automatic preload_sources(input int zero_idx);
        int n;
        for (n = 0; n < 4; n++) begin
            rng = xorshift32(rng);
            src_words[n][63:32] = rng;
            rng = xorshift32(rng);
            src_words[n][31:0] = rng;                          // Never zero from xorshift
            if (n == zero_idx)
                src_words[n] = '0;
        end
    endtask

    task automatic run_program();
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        status_seen = 1'b0;
        idle_cycles = 0;
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (!(status_seen && idle_cycles >= HALT_IDLE))    // Quiet bus after status
            @(posedge clk);
    endtask

    task automatic check_copy();
        logic [DATA_W-1:0] expected;
        logic [DATA_W-1:0] status;
        int                n;
        status = '0;
        if (wr_data_q.size() != 5)
            fail_run($sformatf("Expected 5 bus writes but saw %0d", wr_data_q.size()));
        for (n = 0; n < 4; n++) begin
            expected = (src_words[n] == '0) ? ZERO_FILL : src_words[n];
            if (src_words[n] == '0)
                status = 64'd1;                                // TR0 flags a substitution
            compare_addr("o_ad write address", wr_addr_q[n], DST_BASE + n);
            compare_data($sformatf("o_ad data to 0x%h", DST_BASE + n), wr_data_q[n], expected);
        end
        compare_addr("o_ad status address", wr_addr_q[4], STATUS_ADDR);
        compare_data("o_ad status data", wr_data_q[4], status);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    task automatic test_reset_state();
        preload_sources(-1);
        run_program();                                         // Reset checks in monitor
    endtask

    task automatic test_bus_shape();
        int n;
        preload_sources(-1);
        run_program();
        if (rd_addr_q.size() != 4)
            fail_run($sformatf("Expected 4 bus reads but saw %0d", rd_addr_q.size()));
        for (n = 0; n < 4; n++)
            compare_addr("o_ad read address", rd_addr_q[n], SRC_BASE + n);
    endtask

    task automatic test_copy_nonzero();
        preload_sources(-1);
        run_program();
        check_copy();
    endtask

    task automatic test_zero_substitution();
        preload_sources(2);
        run_program();
        check_copy();
    endtask

    task automatic test_write_order();
        int n;
        preload_sources(-1);
        run_program();
        repeat (HALT_IDLE) @(posedge clk);                     // Halt loop stays quiet
        if (wr_addr_q.size() != 5)
            fail_run($sformatf("Expected 5 bus writes but saw %0d", wr_addr_q.size()));
        for (n = 0; n < 4; n++)
            compare_addr("o_ad write address", wr_addr_q[n], DST_BASE + n);
        compare_addr("o_ad status address", wr_addr_q[4], STATUS_ADDR);
    endtask

    initial begin
        reset    = 1'b1;
        mem_data = '0;
        bus_addr = '0;
        rng      = 32'd17068;                                  // Fixed seed
        test_reset_state();
        test_bus_shape();
        test_copy_nonzero();
        test_zero_substitution();
        test_write_order();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire [micro_pkg::DATA_W-1:0]         i_data,          // Memory read data
    output logic [micro_pkg::DATA_W-1:0]        o_ad,            // Address or write data
    output logic                                o_astb,
    output logic                                o_rd,
    output logic                                o_wr
);
    import micro_pkg::*;

    logic [MC_ADDR_W-1:0] next_addr;
    logic [MC_ADDR_W-1:0] branch_addr;
    seq_op_t              seq_op;
    logic                 cond_pass;
    y_src_t               y_src;
    y_dst_t               y_dst;
    arb_op_t              arb_op;
    ff_op_t               ff_op;
    logic [LIT_W-1:0]     literal;
    logic                 arb_rdy;
    logic                 tr0;
    logic                 tr1;
    logic [DATA_W-1:0]    y;                           // Y bus
    logic                 y_zero;
    logic [DATA_W-1:0]    ureg;                        // Address register
    logic [DATA_W-1:0]    wdata;                       // Write data register
    logic [DATA_W-1:0]    rdata;                       // Read data register
    logic [DATA_W-1:0]    mod_rdata;

    // ------------------------------------------------------------------------
    // Control path
    micro_control u_control (
        .clk(clk), .reset(reset), .i_next_addr(next_addr),
        .i_arb_rdy(arb_rdy), .i_y_zero(y_zero), .i_tr0(tr0), .i_tr1(tr1),
        .o_seq_op(seq_op), .o_branch_addr(branch_addr), .o_cond_pass(cond_pass),
        .o_y_src(y_src), .o_y_dst(y_dst), .o_arb_op(arb_op), .o_ff_op(ff_op),
        .o_literal(literal)
    );

    microsequencer u_seq (
        .clk(clk), .reset(reset), .i_seq_op(seq_op), .i_branch_addr(branch_addr),
        .i_cond_pass(cond_pass), .o_next_addr(next_addr)
    );

    flag_triggers u_flags (
        .clk(clk), .reset(reset), .i_ff_op(ff_op),
        .i_status_we(y_dst == YD_STATUS), .i_y_status(y[1:0]),
        .o_tr0(tr0), .o_tr1(tr1)
    );

    modifier_memory u_modmem (
        .clk(clk), .reset(reset), .i_ff_op(ff_op), .i_we(y_dst == YD_MODREG),
        .i_wdata(y), .o_rdata(mod_rdata)
    );

    bus_arbiter u_arb (
        .clk(clk), .reset(reset), .i_arb_op(arb_op), .i_addr(ureg), .i_wdata(wdata),
        .i_data(i_data), .o_ad(o_ad), .o_astb(o_astb), .o_rd(o_rd), .o_wr(o_wr),
        .o_rdy(arb_rdy), .o_rdata(rdata)
    );

    // ------------------------------------------------------------------------
    // Y bus sources
    always_comb begin
        case (y_src)
            YS_LITERAL: y = {{(DATA_W - LIT_W){1'b0}}, literal};
            YS_RDATA:   y = rdata;
            YS_MODREG:  y = mod_rdata;
            YS_STATUS:  y = {{(DATA_W - 2){1'b0}}, tr1, tr0};
            default:    y = '0;
        endcase
    end

    assign y_zero = (y == '0);                         // Feeds ZERO condition

    // Y bus destinations, loaded at end of microinstruction
    always_ff @(posedge clk) begin
        if (reset)
            ureg <= '0;
        else if (y_dst == YD_UREG)
            ureg <= y;                                 // Load beats increment
        else if (ff_op == FF_INCADR)
            ureg <= ureg + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (y_dst == YD_WDATA)
            wdata <= y;
    end

endmodule

`default_nettype wire

/* bus_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire micro_pkg::arb_op_t             i_arb_op,
    input  wire [micro_pkg::DATA_W-1:0]         i_addr,          // Address register
    input  wire [micro_pkg::DATA_W-1:0]         i_wdata,         // Write data register
    input  wire [micro_pkg::DATA_W-1:0]         i_data,          // External read data
    output logic [micro_pkg::DATA_W-1:0]        o_ad,
    output logic                                o_astb,
    output logic                                o_rd,
    output logic                                o_wr,
    output logic                                o_rdy,
    output logic [micro_pkg::DATA_W-1:0]        o_rdata
);
    import micro_pkg::*;

    arb_state_t state;
    logic       wr_cycle;                              // Latched request kind

    // ------------------------------------------------------------------------
    // One cycle per state, requests only taken when idle
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            wr_cycle <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_arb_op == ARB_READ || i_arb_op == ARB_WRITE) begin
                        state    <= ST_ADDR;
                        wr_cycle <= (i_arb_op == ARB_WRITE);
                    end
                end
                ST_ADDR: state <= ST_DATA;
                ST_DATA: state <= ST_DONE;
                default: state <= ST_IDLE;             // DONE back to idle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DATA && !wr_cycle)
            o_rdata <= i_data;                         // Sample at end of read
    end

    assign o_astb = (state == ST_ADDR);
    assign o_rd   = (state == ST_DATA) && !wr_cycle;
    assign o_wr   = (state == ST_DATA) && wr_cycle;
    assign o_rdy  = (state == ST_DONE);

    // Shared address/data lines
    always_comb begin
        case (state)
            ST_ADDR: o_ad = i_addr;
            ST_DATA: o_ad = wr_cycle ? i_wdata : '0;
            default: o_ad = '0;
        endcase
    end

endmodule

`default_nettype wire

/* modifier_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module modifier_memory (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire micro_pkg::ff_op_t              i_ff_op,
    input  wire                                 i_we,            // Y destination is MODREG
    input  wire [micro_pkg::DATA_W-1:0]         i_wdata,
    output logic [micro_pkg::DATA_W-1:0]        o_rdata
);
    import micro_pkg::*;

    logic [DATA_W-1:0]            mem [MOD_DEPTH];     // Modifier entries
    logic [$clog2(MOD_DEPTH)-1:0] ptr;                 // Entry pointer, wraps

    always_ff @(posedge clk) begin
        if (reset)
            ptr <= '0;
        else if (i_ff_op == FF_CLRPTR)
            ptr <= '0;
        else if (i_ff_op == FF_INCPTR)
            ptr <= ptr + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (i_we)
            mem[ptr] <= i_wdata;                       // Old pointer on INCPTR
    end

    assign o_rdata = mem[ptr];                         // Asynchronous read

endmodule

`default_nettype wire

/* flag_triggers.sv */
`timescale 1ns/1ns
`default_nettype none

module flag_triggers (
    input  wire                     clk,
    input  wire                     reset,
    input  wire micro_pkg::ff_op_t  i_ff_op,
    input  wire                     i_status_we,        // Y destination is STATUS
    input  wire [1:0]               i_y_status,         // {TR1, TR0} from Y
    output logic                    o_tr0,
    output logic                    o_tr1
);
    import micro_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_tr0 <= 1'b0;
            o_tr1 <= 1'b0;
        end else if (i_status_we) begin                 // Y write wins
            o_tr1 <= i_y_status[1];
            o_tr0 <= i_y_status[0];
        end else begin
            case (i_ff_op)
                FF_SETTR0: o_tr0 <= 1'b1;
                FF_CLRTR0: o_tr0 <= 1'b0;
                FF_SETTR1: o_tr1 <= 1'b1;
                FF_CLRTR1: o_tr1 <= 1'b0;
                default:   ;                            // Pointer and address ops
            endcase
        end
    end

endmodule

`default_nettype wire

/* micro_control.sv */
`timescale 1ns/1ns
`default_nettype none

module micro_control (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire [micro_pkg::MC_ADDR_W-1:0]      i_next_addr,     // From sequencer
    input  wire                                 i_arb_rdy,
    input  wire                                 i_y_zero,
    input  wire                                 i_tr0,
    input  wire                                 i_tr1,
    output micro_pkg::seq_op_t                  o_seq_op,
    output logic [micro_pkg::MC_ADDR_W-1:0]     o_branch_addr,
    output logic                                o_cond_pass,
    output micro_pkg::y_src_t                   o_y_src,
    output micro_pkg::y_dst_t                   o_y_dst,
    output micro_pkg::arb_op_t                  o_arb_op,
    output micro_pkg::ff_op_t                   o_ff_op,
    output logic [micro_pkg::LIT_W-1:0]         o_literal
);
    import micro_pkg::*;

    logic [MC_WORD_W-1:0] rom [MC_DEPTH];              // Microprogram store
    logic [MC_WORD_W-1:0] pipe;                        // Pipeline register
    cond_t                cond_sel;
    logic                 cond_inv;
    logic                 cond;                        // Selected condition

    initial begin
        $readmemh("microcode.hex", rom);
    end

    // ------------------------------------------------------------------------
    // Registered ROM read, one word per cycle
    always_ff @(posedge clk) begin
        if (reset)
            pipe <= '0;                                // All-zero word is JZ
        else
            pipe <= rom[i_next_addr];
    end

    // Field decode
    assign o_seq_op      = seq_op_t'(pipe[F_SEQ_LO +: $bits(seq_op_t)]);
    assign o_branch_addr = pipe[F_NEXT_LO +: MC_ADDR_W];
    assign cond_sel      = cond_t'(pipe[F_CSEL_LO +: $bits(cond_t)]);
    assign cond_inv      = pipe[F_CINV_LO];
    assign o_y_src       = y_src_t'(pipe[F_YSRC_LO +: $bits(y_src_t)]);
    assign o_y_dst       = y_dst_t'(pipe[F_YDST_LO +: $bits(y_dst_t)]);
    assign o_arb_op      = arb_op_t'(pipe[F_ARB_LO +: $bits(arb_op_t)]);
    assign o_ff_op       = ff_op_t'(pipe[F_FF_LO +: $bits(ff_op_t)]);
    assign o_literal     = pipe[F_LIT_LO +: LIT_W];

    // ------------------------------------------------------------------------
    // Condition multiplexer
    always_comb begin
        case (cond_sel)
            C_YES:    cond = 1'b1;
            C_ARBRDY: cond = i_arb_rdy;                // Bus cycle finished
            C_ZERO:   cond = i_y_zero;                 // Current Y bus is zero
            C_TR0:    cond = i_tr0;
            C_TR1:    cond = i_tr1;
            default:  cond = 1'b1;                     // Spare codes pass
        endcase
    end

    assign o_cond_pass = cond ^ cond_inv;              // Invert bit flips the sense

endmodule

`default_nettype wire

/* microsequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module microsequencer (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire micro_pkg::seq_op_t             i_seq_op,
    input  wire [micro_pkg::MC_ADDR_W-1:0]      i_branch_addr,   // Also counter load value
    input  wire                                 i_cond_pass,
    output logic [micro_pkg::MC_ADDR_W-1:0]     o_next_addr
);
    import micro_pkg::*;

    logic [MC_ADDR_W-1:0] upc;                         // Address of current word + 1
    logic [MC_ADDR_W-1:0] stack [STACK_DEPTH];         // Return addresses
    logic [SP_W-1:0]      sp;                          // Filled entries
    logic [SP_W-1:0]      wr_idx;                      // Push slot
    logic [MC_ADDR_W-1:0] counter;                     // Loop counter
    logic [MC_ADDR_W-1:0] top;                         // Top of stack
    logic                 ct_zero;
    logic                 push;
    logic                 pop;
    logic                 clear;
    logic                 load_ct;
    logic                 dec_ct;

    // Underflow reads entry 0, overflow rewrites the top entry
    assign top     = (sp == '0) ? stack[0] : stack[sp - 1'b1];
    assign wr_idx  = (sp == SP_W'(STACK_DEPTH)) ? SP_W'(STACK_DEPTH - 1) : sp;
    assign ct_zero = (counter == '0);

    // ------------------------------------------------------------------------
    // Next address select
    always_comb begin
        o_next_addr = upc;                             // Default continue
        push        = 1'b0;
        pop         = 1'b0;
        clear       = 1'b0;
        load_ct     = 1'b0;
        dec_ct      = 1'b0;
        case (i_seq_op)
            SEQ_JZ: begin
                o_next_addr = '0;
                clear       = 1'b1;                    // Empty the stack
            end
            SEQ_CJS: begin
                if (i_cond_pass) begin
                    o_next_addr = i_branch_addr;
                    push        = 1'b1;
                end
            end
            SEQ_JMAP: o_next_addr = i_branch_addr;     // No map ROM, branch field only
            SEQ_CJP: begin
                if (i_cond_pass)
                    o_next_addr = i_branch_addr;
            end
            SEQ_PUSH: begin
                push    = 1'b1;
                load_ct = i_cond_pass;                 // Optional counter load
            end
            SEQ_RPCT: begin
                if (!ct_zero) begin
                    o_next_addr = i_branch_addr;
                    dec_ct      = 1'b1;
                end
            end
            SEQ_CRTN: begin
                if (i_cond_pass) begin
                    o_next_addr = top;
                    pop         = 1'b1;
                end
            end
            SEQ_LDCT: load_ct = 1'b1;
            SEQ_TWB: begin
                pop = i_cond_pass | ct_zero;           // Leave the loop
                if (!i_cond_pass && !ct_zero) begin
                    o_next_addr = top;                 // Loop again
                    dec_ct      = 1'b1;
                end else if (!i_cond_pass) begin
                    o_next_addr = i_branch_addr;       // Count ran out
                end
            end
            default: ;                                 // CONT and spare codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            upc     <= '0;
            sp      <= '0;
            counter <= '0;
        end else begin
            upc <= o_next_addr + 1'b1;
            if (clear)
                sp <= '0;
            else if (push && sp != SP_W'(STACK_DEPTH))
                sp <= sp + 1'b1;
            else if (pop && sp != '0)
                sp <= sp - 1'b1;
            if (load_ct)
                counter <= i_branch_addr;
            else if (dec_ct)
                counter <= counter - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            stack[wr_idx] <= upc;                      // Return to word after call
    end

endmodule

`default_nettype wire

/* micro_pkg.sv */
`default_nettype none

package micro_pkg;

    // ------------------------------------------------------------------------
    // Widths and depths
    localparam int MC_ADDR_W   = 8;                          // Microaddress bits
    localparam int MC_DEPTH    = 256;                        // Microcode ROM words
    localparam int MC_WORD_W   = 48;                         // Microinstruction bits
    localparam int DATA_W      = 64;                         // External bus and data path
    localparam int LIT_W       = 20;                         // Literal field
    localparam int MOD_DEPTH   = 16;                         // Modifier entries
    localparam int STACK_DEPTH = 5;                          // Subroutine stack entries
    localparam int SP_W        = $clog2(STACK_DEPTH + 1);    // Stack fill count

    // ------------------------------------------------------------------------
    // Low bit of each microinstruction field, bit 47 spare
    localparam int F_LIT_LO  = 0;                            // Literal [19:0]
    localparam int F_FF_LO   = 20;                           // Flag trigger op [22:20]
    localparam int F_ARB_LO  = 23;                           // Arbiter request [24:23]
    localparam int F_YDST_LO = 25;                           // Y destination [27:25]
    localparam int F_YSRC_LO = 28;                           // Y source [30:28]
    localparam int F_CINV_LO = 31;                           // Condition invert [31]
    localparam int F_CSEL_LO = 32;                           // Condition select [34:32]
    localparam int F_NEXT_LO = 35;                           // Branch address [42:35]
    localparam int F_SEQ_LO  = 43;                           // Sequencer op [46:43]

    // ------------------------------------------------------------------------
    // Sequencer opcodes, 2910 numbering
    typedef enum logic [3:0] {
        SEQ_JZ   = 4'd0,                                     // Jump zero, clear stack
        SEQ_CJS  = 4'd1,                                     // Cond jump subroutine
        SEQ_JMAP = 4'd2,                                     // Jump to branch field
        SEQ_CJP  = 4'd3,                                     // Cond jump
        SEQ_PUSH = 4'd4,                                     // Push, cond load counter
        SEQ_RPCT = 4'd9,                                     // Repeat while counter nonzero
        SEQ_CRTN = 4'd10,                                    // Cond return
        SEQ_LDCT = 4'd12,                                    // Load counter
        SEQ_CONT = 4'd14,                                    // Continue
        SEQ_TWB  = 4'd15                                     // Three-way branch
    } seq_op_t;

    typedef enum logic [2:0] {
        C_YES    = 3'd0,                                     // Always
        C_ARBRDY = 3'd1,                                     // Arbiter done
        C_ZERO   = 3'd2,                                     // Y bus all zero
        C_TR0    = 3'd3,
        C_TR1    = 3'd4
    } cond_t;

    typedef enum logic [2:0] {
        YS_NONE    = 3'd0,
        YS_LITERAL = 3'd1,                                   // Zero-extended literal
        YS_RDATA   = 3'd2,                                   // Read data register
        YS_MODREG  = 3'd3,                                   // Modifier under pointer
        YS_STATUS  = 3'd4                                    // {TR1, TR0}
    } y_src_t;

    typedef enum logic [2:0] {
        YD_NONE   = 3'd0,
        YD_UREG   = 3'd1,                                    // Address register
        YD_WDATA  = 3'd2,                                    // Write data register
        YD_MODREG = 3'd3,
        YD_STATUS = 3'd4
    } y_dst_t;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_READ  = 2'd1,
        ARB_WRITE = 2'd2
    } arb_op_t;

    typedef enum logic [2:0] {
        FF_NOP    = 3'd0,
        FF_SETTR0 = 3'd1,
        FF_CLRTR0 = 3'd2,
        FF_SETTR1 = 3'd3,
        FF_CLRTR1 = 3'd4,
        FF_CLRPTR = 3'd5,                                    // Modifier pointer to 0
        FF_INCPTR = 3'd6,                                    // Modifier pointer + 1
        FF_INCADR = 3'd7                                     // Address register + 1
    } ff_op_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ADDR = 2'd1,                                      // Address strobe
        ST_DATA = 2'd2,                                      // Read or write strobe
        ST_DONE = 2'd3                                       // Ready pulse
    } arb_state_t;

endpackage

`default_nettype wire
